/* project.f */
verilog/matrix_cfg_pkg.sv
verilog/matrix_cmd_pkg.sv
verilog/uart_rx.sv
verilog/cmd_decoder.sv
verilog/fb_arbiter.sv
verilog/framebuffer_ram.sv
verilog/matrix_scan.sv
verilog/led_matrix_top.sv
dv/led_matrix_checks.sv
dv/led_matrix_tb.sv

/* dv/led_matrix_tb.sv */
// testbench for the led matrix driver, sends serial commands and checks the panel against a model
`default_nettype none

module led_matrix_tb;
	timeunit 1ns;
	timeprecision 100ps;

	import matrix_cfg_pkg::*;
	import matrix_cmd_pkg::*;

	// shift, latch and lit time of every row and plane
	localparam int frame_cycles = num_rows_half *
		(num_planes * (num_cols * 4 + 1) + plane_base_cycles * ((1 << num_planes) - 1));
	localparam int frame_latches = num_rows_half * num_planes;
	localparam int reset_cycles = 16;
	// dut needs a few cycles past the stop bit to show a change
	localparam int settle_cycles = 24;
	localparam int rand_writes = 48;
	// fill, random writes, enable commands, junk opcodes
	localparam int total_bytes = 4 * (1 << fb_addr_bits) + 4 * rand_writes +
		2 * (rand_writes / 6 + 1) + 3;
	localparam int watchdog_ns = 8 * (reset_cycles +
		total_bytes * 10 * uart_ticks_per_bit + 3 * frame_cycles);

	logic clk_root = 1'b0;
	logic reset;
	logic uart_line;
	logic pixel_clk;
	logic row_latch;
	logic output_enable;
	logic [row_bits-1:0] row_addr;
	logic [2:0] rgb_top;
	logic [2:0] rgb_bottom;
	logic [7:0] cmd_count;

	// reference framebuffer and masks
	logic [pixel_bits-1:0] fb_model [0:(1 << fb_addr_bits)-1];
	logic [2:0] model_rgb;
	logic [num_planes-1:0] model_plane;
	logic [7:0] exp_count;

	int seed = 71;
	int cycle_no = 0;
	int update_cycle = 0;
	bit fill_done = 1'b0;
	int latches;
	int pix_col;
	int value_errors;
	int protocol_errors;

	int scan_plane;
	logic [row_bits-1:0] scan_row;
	logic [col_bits-1:0] scan_col;
	logic [2:0] exp_top;
	logic [2:0] exp_bottom;
	logic [row_bits-1:0] exp_row;
	logic pixel_check_en;
	logic count_check_en;

	always #4 clk_root = ~clk_root;

	led_matrix_top led_matrix_top_i (
		.clk_root(clk_root),
		.reset(reset),
		.uart_rx(uart_line),
		.pixel_clk(pixel_clk),
		.row_latch(row_latch),
		.output_enable(output_enable),
		.row_addr(row_addr),
		.rgb_top(rgb_top),
		.rgb_bottom(rgb_bottom),
		.cmd_count(cmd_count)
	);

	led_matrix_checks led_matrix_checks_i (
		.clk_root(clk_root),
		.reset(reset),
		.pixel_clk(pixel_clk),
		.row_latch(row_latch),
		.output_enable(output_enable),
		.row_addr(row_addr),
		.rgb_top(rgb_top),
		.rgb_bottom(rgb_bottom),
		.cmd_count(cmd_count),
		.exp_top(exp_top),
		.exp_bottom(exp_bottom),
		.exp_row(exp_row),
		.exp_count(exp_count),
		.pixel_check_en(pixel_check_en),
		.count_check_en(count_check_en),
		.value_errors(value_errors),
		.protocol_errors(protocol_errors)
	);

	// red lands in bit 0, blue in bit 2
	function automatic logic [2:0] expected_colour(input logic [pixel_bits-1:0] pix,
		input int plane, input logic [2:0] rgb_mask, input logic [num_planes-1:0] plane_mask);
		logic [2:0] bits;
		if (!plane_mask[plane])
			return 3'b000;
		bits = {pix[2 + plane], pix[8 + plane], pix[13 + plane]};
		return bits & rgb_mask;
	endfunction

	// three planes per row, rows wrap after the last one
	function automatic logic [row_bits-1:0] row_of_latch(input int n);
		return row_bits'((n / num_planes) % num_rows_half);
	endfunction

	// scan position from latch and pixel_clk pulses
	always @(posedge clk_root) begin
		cycle_no <= cycle_no + 1;
		if (reset) begin
			latches <= 0;
			pix_col <= 0;
		end else if (row_latch) begin
			latches <= latches + 1;
			pix_col <= 0;
		end else if (pixel_clk) begin
			pix_col <= pix_col + 1;
		end
	end

	assign scan_plane = latches % num_planes;
	assign scan_row = row_of_latch(latches);
	assign scan_col = col_bits'(pix_col);
	assign exp_top = expected_colour(fb_model[{1'b0, scan_row, scan_col}], scan_plane,
		model_rgb, model_plane);
	assign exp_bottom = expected_colour(fb_model[{1'b1, scan_row, scan_col}], scan_plane,
		model_rgb, model_plane);
	// row select moves with the latch pulse itself
	assign exp_row = row_latch ? row_of_latch(latches) :
		(latches == 0 ? '0 : row_of_latch(latches - 1));
	assign count_check_en = (cycle_no - update_cycle) >= settle_cycles;
	assign pixel_check_en = fill_done && count_check_en;

	// one serial bit, driven just after the edge
	task automatic hold_bit(input logic v);
		@(posedge clk_root);
		#1 uart_line = v;
		repeat (uart_ticks_per_bit - 1) @(posedge clk_root);
	endtask

	// start and data bits, lsb first, then raise the stop bit
	task automatic frame_head(input logic [7:0] b);
		hold_bit(1'b0);
		for (int i = 0; i < 8; i++)
			hold_bit(b[i]);
		@(posedge clk_root);
		#1 uart_line = 1'b1;
	endtask

	task automatic finish_stop();
		repeat (uart_ticks_per_bit - 1) @(posedge clk_root);
	endtask

	task automatic send_byte(input logic [7:0] b);
		frame_head(b);
		finish_stop();
	endtask

	task automatic write_pixel(input logic [7:0] a, input logic [pixel_bits-1:0] d);
		send_byte(cmd_pixel);
		send_byte(a);
		send_byte(d[15:8]);
		frame_head(d[7:0]);
		// write lands during this stop bit
		fb_model[a] = d;
		exp_count = exp_count + 1'b1;
		update_cycle = cycle_no;
		finish_stop();
	endtask

	task automatic set_enables(input logic [5:0] m);
		send_byte(cmd_enable);
		frame_head({2'b00, m});
		model_rgb = m[2:0];
		model_plane = m[5:3];
		exp_count = exp_count + 1'b1;
		update_cycle = cycle_no;
		finish_stop();
	endtask

	// unknown opcode, count must stay put
	task automatic send_junk(input logic [7:0] b);
		frame_head(b);
		update_cycle = cycle_no;
		finish_stop();
	endtask

	initial begin : stimulus
		logic [7:0] a;
		logic [pixel_bits-1:0] d;
		int final_latches;
		reset = 1'b1;
		uart_line = 1'b1;
		model_rgb = '1;
		model_plane = '1;
		exp_count = '0;
		repeat (reset_cycles) @(posedge clk_root);
		#1 reset = 1'b0;
		repeat (4) @(posedge clk_root);
		// every address once, scan never shows unwritten words
		for (int i = 0; i < (1 << fb_addr_bits); i++)
			write_pixel(8'(i), pixel_bits'($random(seed)));
		fill_done = 1'b1;
		// random overwrites mixed with mask changes and junk
		for (int i = 0; i < rand_writes; i++) begin
			a = 8'($random(seed));
			d = pixel_bits'($random(seed));
			write_pixel(a, d);
			if (i % 6 == 5)
				set_enables(6'($random(seed)));
			if (i % 16 == 9)
				send_junk(8'h20 + 8'(i));
		end
		set_enables(6'h3f);
		// two more frames with the final picture
		final_latches = latches;
		wait (latches >= final_latches + 2 * frame_latches);
		@(posedge clk_root);
		#1;
		$display("closing report: %0d value errors, %0d protocol errors",
			value_errors, protocol_errors);
		if (value_errors + protocol_errors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

	// serial traffic plus three frames
	initial begin : watchdog
		#(watchdog_ns);
		$display("timeout: the run did not end within %0d ns", watchdog_ns);
		$display("closing report: %0d value errors, %0d protocol errors",
			value_errors, protocol_errors);
		$display("SIMULATION FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* dv/led_matrix_checks.sv */
// concurrent checks instanced in the testbench that compare the panel pins with the model
`default_nettype none

module led_matrix_checks (
	input wire logic clk_root,
	input wire logic reset,
	input wire logic pixel_clk,
	input wire logic row_latch,
	input wire logic output_enable,
	input wire logic [matrix_cfg_pkg::row_bits-1:0] row_addr,
	input wire logic [2:0] rgb_top,
	input wire logic [2:0] rgb_bottom,
	input wire logic [7:0] cmd_count,
	input wire logic [2:0] exp_top,
	input wire logic [2:0] exp_bottom,
	input wire logic [matrix_cfg_pkg::row_bits-1:0] exp_row,
	input wire logic [7:0] exp_count,
	input wire logic pixel_check_en,
	input wire logic count_check_en,
	output int value_errors,
	output int protocol_errors
);
	timeunit 1ns;
	timeprecision 100ps;

	int value_errs = 0;
	int protocol_errs = 0;
	logic outputs_idle;

	assign value_errors = value_errs;
	assign protocol_errors = protocol_errs;

	// everything dark and no command counted yet
	assign outputs_idle = !output_enable && !row_latch && !pixel_clk &&
		rgb_top == 3'b000 && rgb_bottom == 3'b000 && cmd_count == 8'd0;

	task automatic wrong_value(input string name, input logic [7:0] got,
		input logic [7:0] want);
		value_errs++;
		$display("[ERROR] %0t ns %s is %0h, expected %0h", $time, name, got, want);
	endtask

	task automatic broken_rule(input string what);
		protocol_errs++;
		$display("%0t ns: %s", $time, what);
	endtask

	// first cycles out of reset
	idle_after_reset: assert property (@(posedge clk_root)
		$fell(reset) |-> outputs_idle [*3])
		else broken_rule("panel pins or cmd_count were not idle right after reset");

	// colour bits against the model pixel at the tracked row, column and plane
	top_colour: assert property (@(posedge clk_root) disable iff (reset)
		pixel_clk && pixel_check_en |-> rgb_top == exp_top)
		else wrong_value("rgb_top", $sampled(rgb_top), $sampled(exp_top));

	bottom_colour: assert property (@(posedge clk_root) disable iff (reset)
		pixel_clk && pixel_check_en |-> rgb_bottom == exp_bottom)
		else wrong_value("rgb_bottom", $sampled(rgb_bottom), $sampled(exp_bottom));

	// panel must be dark while shifting or latching
	oe_dark_strobes: assert property (@(posedge clk_root) disable iff (reset)
		output_enable |-> !pixel_clk && !row_latch)
		else broken_rule("output_enable was high together with pixel_clk or row_latch");

	row_change_dark: assert property (@(posedge clk_root) disable iff (reset)
		!$stable(row_addr) |-> !output_enable)
		else broken_rule("row_addr changed while output_enable was high");

	// row select follows the latch count
	row_follows_latches: assert property (@(posedge clk_root) disable iff (reset)
		row_addr == exp_row)
		else wrong_value("row_addr", $sampled(row_addr), $sampled(exp_row));

	count_matches: assert property (@(posedge clk_root) disable iff (reset)
		count_check_en |-> cmd_count == exp_count)
		else wrong_value("cmd_count", $sampled(cmd_count), $sampled(exp_count));

endmodule

`default_nettype wire

/* verilog/led_matrix_top.sv */
// led matrix driver top, serial command input to hub75 panel pins
`default_nettype none

module led_matrix_top (
	input wire logic clk_root,
	input wire logic reset,
	input wire logic uart_rx,
	output logic pixel_clk,
	output logic row_latch,
	output logic output_enable,
	output logic [matrix_cfg_pkg::row_bits-1:0] row_addr,
	output logic [2:0] rgb_top,
	output logic [2:0] rgb_bottom,
	output logic [7:0] cmd_count
);
	import matrix_cfg_pkg::*;

	// receiver to decoder
	logic [7:0] rx_data;
	logic rx_valid;

	// decoder write port
	logic wr_req;
	logic wr_grant;
	logic [fb_addr_bits-1:0] wr_addr;
	logic [pixel_bits-1:0] wr_data;

	// masks for the scan engine
	logic [2:0] rgb_enable;
	logic [num_planes-1:0] plane_enable;

	// scan read port
	logic rd_req;
	logic [fb_addr_bits-1:0] rd_addr;
	logic [pixel_bits-1:0] rd_data;

	// memory port
	logic mem_en;
	logic mem_we;
	logic [fb_addr_bits-1:0] mem_addr;
	logic [pixel_bits-1:0] mem_wdata;
	logic [pixel_bits-1:0] mem_rdata;

	uart_rx uart_rx_i (
		.clk_root(clk_root),
		.reset(reset),
		.rx(uart_rx),
		.rx_data(rx_data),
		.rx_valid(rx_valid)
	);

	cmd_decoder cmd_decoder_i (
		.clk_root(clk_root),
		.reset(reset),
		.rx_data(rx_data),
		.rx_valid(rx_valid),
		.wr_req(wr_req),
		.wr_addr(wr_addr),
		.wr_data(wr_data),
		.wr_grant(wr_grant),
		.rgb_enable(rgb_enable),
		.plane_enable(plane_enable),
		.cmd_count(cmd_count)
	);

	fb_arbiter fb_arbiter_i (
		.clk_root(clk_root),
		.reset(reset),
		.rd_req(rd_req),
		.rd_addr(rd_addr),
		.rd_data(rd_data),
		.wr_req(wr_req),
		.wr_addr(wr_addr),
		.wr_data(wr_data),
		.wr_grant(wr_grant),
		.mem_en(mem_en),
		.mem_we(mem_we),
		.mem_addr(mem_addr),
		.mem_wdata(mem_wdata),
		.mem_rdata(mem_rdata)
	);

	framebuffer_ram framebuffer_ram_i (
		.clk_root(clk_root),
		.mem_en(mem_en),
		.mem_we(mem_we),
		.mem_addr(mem_addr),
		.mem_wdata(mem_wdata),
		.mem_rdata(mem_rdata)
	);

	matrix_scan matrix_scan_i (
		.clk_root(clk_root),
		.reset(reset),
		.rgb_enable(rgb_enable),
		.plane_enable(plane_enable),
		.rd_req(rd_req),
		.rd_addr(rd_addr),
		.rd_data(rd_data),
		.pixel_clk(pixel_clk),
		.row_latch(row_latch),
		.output_enable(output_enable),
		.row_addr(row_addr),
		.rgb_top(rgb_top),
		.rgb_bottom(rgb_bottom)
	);

endmodule

`default_nettype wire

/* verilog/matrix_scan.sv */
// hub75 scan engine under the led matrix top that shifts columns, latches rows and lights each plane
`default_nettype none

module matrix_scan (
	input wire logic clk_root,
	input wire logic reset,
	input wire logic [2:0] rgb_enable,
	input wire logic [matrix_cfg_pkg::num_planes-1:0] plane_enable,
	output logic rd_req,
	output logic [matrix_cfg_pkg::fb_addr_bits-1:0] rd_addr,
	input wire logic [matrix_cfg_pkg::pixel_bits-1:0] rd_data,
	output logic pixel_clk,
	output logic row_latch,
	output logic output_enable,
	output logic [matrix_cfg_pkg::row_bits-1:0] row_addr,
	output logic [2:0] rgb_top,
	output logic [2:0] rgb_bottom
);
	import matrix_cfg_pkg::*;

	typedef enum logic [1:0] {
		scan_shift,
		scan_latch,
		scan_show
	} scan_mode_t;

	scan_mode_t mode;
	logic [col_bits-1:0] col;
	logic [1:0] phase;
	logic [row_bits-1:0] row;
	logic [plane_bits-1:0] plane;
	logic [show_cnt_bits-1:0] show_cnt;
	logic [2:0] top_sel;

	// pick this plane's bit from the top three of each channel and mask it
	function automatic logic [2:0] colour_bits(
		input logic [pixel_bits-1:0] pix,
		input logic [plane_bits-1:0] p,
		input logic [2:0] rgb_en,
		input logic [num_planes-1:0] plane_en
	);
		logic [2:0] raw;
		raw[0] = pix[13 + p];
		raw[1] = pix[8 + p];
		raw[2] = pix[2 + p];
		return raw & rgb_en & {3{plane_en[p]}};
	endfunction

	// phase 0 reads the top half and phase 1 the bottom half
	assign rd_req = (mode == scan_shift) && !phase[1];
	assign rd_addr = {phase[0], row, col};

	always_ff @(posedge clk_root) begin
		if (reset) begin
			mode <= scan_shift;
			col <= '0;
			phase <= '0;
			row <= '0;
			plane <= '0;
			show_cnt <= '0;
		end else begin
			case (mode)
				scan_shift: begin
					phase <= phase + 1'b1;
					if (phase == 2'd3) begin
						if (col == col_bits'(num_cols - 1)) begin
							col <= '0;
							mode <= scan_latch;
						end else begin
							col <= col + 1'b1;
						end
					end
				end
				scan_latch: begin
					// lit window grows with plane weight
					show_cnt <= show_cnt_bits'((plane_base_cycles << plane) - 1);
					mode <= scan_show;
				end
				scan_show: begin
					if (show_cnt == '0) begin
						mode <= scan_shift;
						if (plane == plane_bits'(num_planes - 1)) begin
							plane <= '0;
							if (row == row_bits'(num_rows_half - 1))
								row <= '0;
							else
								row <= row + 1'b1;
						end else begin
							plane <= plane + 1'b1;
						end
					end else begin
						show_cnt <= show_cnt - 1'b1;
					end
				end
				default: mode <= scan_shift;
			endcase
		end
	end

	// top pixel comes back in phase 1
	always_ff @(posedge clk_root) begin
		if (mode == scan_shift && phase == 2'd1)
			top_sel <= colour_bits(rd_data, plane, rgb_enable, plane_enable);
	end

	// panel pins run one cycle behind the scan state
	// colour lands a cycle before its pixel_clk
	always_ff @(posedge clk_root) begin
		if (reset) begin
			pixel_clk <= 1'b0;
			row_latch <= 1'b0;
			output_enable <= 1'b0;
			row_addr <= '0;
			rgb_top <= '0;
			rgb_bottom <= '0;
		end else begin
			pixel_clk <= (mode == scan_shift) && (phase == 2'd3);
			row_latch <= (mode == scan_latch);
			output_enable <= (mode == scan_show);
			// new row shows up with the latch while the panel is still dark
			if (mode == scan_latch)
				row_addr <= row;
			if (mode == scan_shift && phase == 2'd2) begin
				rgb_top <= top_sel;
				rgb_bottom <= colour_bits(rd_data, plane, rgb_enable, plane_enable);
			end
		end
	end

	// row select only moves while the panel is dark on both sides of the change
	row_quiet: assert property (@(posedge clk_root) disable iff (reset)
		!$stable(row_addr) |-> !output_enable && !$past(output_enable));

endmodule

`default_nettype wire

/* verilog/framebuffer_ram.sv */
// 256 x 16 single port pixel store, read data registered one cycle after the access
`default_nettype none

module framebuffer_ram (
	input wire logic clk_root,
	input wire logic mem_en,
	input wire logic mem_we,
	input wire logic [matrix_cfg_pkg::fb_addr_bits-1:0] mem_addr,
	input wire logic [matrix_cfg_pkg::pixel_bits-1:0] mem_wdata,
	output logic [matrix_cfg_pkg::pixel_bits-1:0] mem_rdata
);
	import matrix_cfg_pkg::*;

	// one word per pixel, both halves
	logic [pixel_bits-1:0] mem [0:(1 << fb_addr_bits)-1];

	// read first, a write returns the old word
	always_ff @(posedge clk_root) begin
		if (mem_en) begin
			if (mem_we)
				mem[mem_addr] <= mem_wdata;
			mem_rdata <= mem[mem_addr];
		end
	end

endmodule

`default_nettype wire

/* verilog/fb_arbiter.sv */
// arbiter under the led matrix top that shares the one framebuffer port and serves scan reads first
`default_nettype none

module fb_arbiter (
	input wire logic clk_root,
	input wire logic reset,
	input wire logic rd_req,
	input wire logic [matrix_cfg_pkg::fb_addr_bits-1:0] rd_addr,
	output logic [matrix_cfg_pkg::pixel_bits-1:0] rd_data,
	input wire logic wr_req,
	input wire logic [matrix_cfg_pkg::fb_addr_bits-1:0] wr_addr,
	input wire logic [matrix_cfg_pkg::pixel_bits-1:0] wr_data,
	output logic wr_grant,
	output logic mem_en,
	output logic mem_we,
	output logic [matrix_cfg_pkg::fb_addr_bits-1:0] mem_addr,
	output logic [matrix_cfg_pkg::pixel_bits-1:0] mem_wdata,
	input wire logic [matrix_cfg_pkg::pixel_bits-1:0] mem_rdata
);
	import matrix_cfg_pkg::*;

	logic rd_inflight;

	// write only gets the port in a cycle with no read
	assign wr_grant = wr_req && !rd_req;

	assign mem_en = rd_req || wr_req;
	assign mem_we = wr_grant;
	assign mem_addr = rd_req ? rd_addr : wr_addr;
	assign mem_wdata = wr_data;

	// read data returns one cycle after the request
	always_ff @(posedge clk_root) begin
		if (reset)
			rd_inflight <= 1'b0;
		else
			rd_inflight <= rd_req;
	end

	// ram output only passes through in the cycle after a read
	assign rd_data = rd_inflight ? mem_rdata : {pixel_bits{1'b0}};

	// scan never reads more than two cycles in a row
	wr_latency: assert property (@(posedge clk_root) disable iff (reset)
		wr_req |-> ##[0:2] wr_grant);

endmodule

`default_nettype wire

/* verilog/cmd_decoder.sv */
// turns received bytes into framebuffer writes and enable mask updates, counts finished commands
`default_nettype none

module cmd_decoder (
	input wire logic clk_root,
	input wire logic reset,
	input wire logic [7:0] rx_data,
	input wire logic rx_valid,
	output logic wr_req,
	output logic [matrix_cfg_pkg::fb_addr_bits-1:0] wr_addr,
	output logic [matrix_cfg_pkg::pixel_bits-1:0] wr_data,
	input wire logic wr_grant,
	output logic [2:0] rgb_enable,
	output logic [matrix_cfg_pkg::num_planes-1:0] plane_enable,
	output logic [7:0] cmd_count
);
	import matrix_cfg_pkg::*;
	import matrix_cmd_pkg::*;

	decode_state_t state;

	always_ff @(posedge clk_root) begin
		if (reset) begin
			state <= idle;
			wr_req <= 1'b0;
			// everything lit until told otherwise
			rgb_enable <= '1;
			plane_enable <= '1;
			cmd_count <= '0;
		end else begin
			case (state)
				idle: begin
					if (rx_valid) begin
						case (cmd_opcode_t'(rx_data))
							cmd_pixel: state <= addr;
							cmd_enable: state <= mask;
							// anything else is dropped
							default: state <= idle;
						endcase
					end
				end
				addr: begin
					if (rx_valid)
						state <= data_hi;
				end
				data_hi: begin
					if (rx_valid)
						state <= data_lo;
				end
				data_lo: begin
					// pixel complete, hold request until arbiter takes it
					if (rx_valid) begin
						wr_req <= 1'b1;
						state <= write_wait;
					end
				end
				write_wait: begin
					if (wr_grant) begin
						wr_req <= 1'b0;
						cmd_count <= cmd_count + 1'b1;
						state <= idle;
					end
				end
				mask: begin
					if (rx_valid) begin
						rgb_enable <= rx_data[2:0];
						plane_enable <= rx_data[5:3];
						cmd_count <= cmd_count + 1'b1;
						state <= idle;
					end
				end
				default: state <= idle;
			endcase
		end
	end

	// payload bytes, held stable while wr_req is up
	always_ff @(posedge clk_root) begin
		if (rx_valid) begin
			case (state)
				addr: wr_addr <= rx_data;
				data_hi: wr_data[pixel_bits-1 -: 8] <= rx_data;
				data_lo: wr_data[7:0] <= rx_data;
				default: ;
			endcase
		end
	end

	// request must not move until granted
	wr_hold: assert property (@(posedge clk_root) disable iff (reset)
		wr_req && !wr_grant |=> wr_req && $stable(wr_addr) && $stable(wr_data));

	// byte spacing on the line keeps writes ahead of the next byte
	no_byte_in_wait: assert property (@(posedge clk_root) disable iff (reset)
		state == write_wait |-> !rx_valid);

endmodule

`default_nettype wire

/* verilog/uart_rx.sv */
// serial receiver for command bytes, 8N1, emits one rx_valid pulse per good frame
`default_nettype none

module uart_rx (
	input wire logic clk_root,
	input wire logic reset,
	input wire logic rx,
	output logic [7:0] rx_data,
	output logic rx_valid
);
	import matrix_cfg_pkg::*;

	logic [1:0] rx_sync;
	logic line;
	logic busy;
	logic [uart_tick_bits-1:0] tick_cnt;
	logic [3:0] bit_idx;
	logic [7:0] shift;
	logic sample;

	// two flop synchroniser, line idles high
	assign line = rx_sync[1];
	// middle of the current bit period
	assign sample = busy && (tick_cnt == uart_tick_bits'(uart_ticks_per_bit / 2));

	always_ff @(posedge clk_root) begin
		if (reset) begin
			rx_sync <= 2'b11;
			busy <= 1'b0;
			tick_cnt <= '0;
			bit_idx <= '0;
			rx_valid <= 1'b0;
		end else begin
			rx_sync <= {rx_sync[0], rx};
			rx_valid <= 1'b0;
			if (!busy) begin
				// falling edge starts a frame
				if (!line) begin
					busy <= 1'b1;
					tick_cnt <= uart_tick_bits'(1);
					bit_idx <= '0;
				end
			end else begin
				if (tick_cnt == uart_tick_bits'(uart_ticks_per_bit - 1))
					tick_cnt <= '0;
				else
					tick_cnt <= tick_cnt + 1'b1;
				if (sample) begin
					bit_idx <= bit_idx + 1'b1;
					if (bit_idx == 4'd0) begin
						// start bit gone high again, glitch
						if (line)
							busy <= 1'b0;
					end else if (bit_idx == 4'd9) begin
						// stop bit, bad framing drops the byte
						busy <= 1'b0;
						rx_valid <= line;
					end
				end
			end
		end
	end

	// data bits arrive lsb first
	always_ff @(posedge clk_root) begin
		if (sample && bit_idx != 4'd0 && bit_idx != 4'd9)
			shift <= {line, shift[7:1]};
	end

	assign rx_data = shift;

endmodule

`default_nettype wire

/* verilog/matrix_cmd_pkg.sv */
// command byte values and decoder state encoding for the serial command path
`default_nettype none

package matrix_cmd_pkg;

	// ascii opcodes sent over the serial line
	typedef enum logic [7:0] {
		cmd_pixel  = 8'h50,
		cmd_enable = 8'h45
	} cmd_opcode_t;

	// decoder walks opcode, then payload bytes
	typedef enum logic [2:0] {
		idle,
		addr,
		data_hi,
		data_lo,
		mask,
		write_wait
	} decode_state_t;

endpackage

`default_nettype wire

/* verilog/matrix_cfg_pkg.sv */
// panel geometry, framebuffer and timing constants shared by the led matrix design and its testbench
`default_nettype none

package matrix_cfg_pkg;

	// 16x16 panel, two halves of 8 rows scanned together
	localparam int num_cols = 16;
	localparam int num_rows_half = 8;
	localparam int col_bits = 4;
	localparam int row_bits = 3;

	// address is {half, row, col}
	localparam int fb_addr_bits = 8;
	// rgb565
	localparam int pixel_bits = 16;

	// binary coded brightness, plane p lit for base << p cycles
	localparam int num_planes = 3;
	localparam int plane_bits = $clog2(num_planes);
	localparam int plane_base_cycles = 16;
	localparam int show_cnt_bits = $clog2(plane_base_cycles << (num_planes - 1));

	// serial line, clk_root cycles per bit
	localparam int uart_ticks_per_bit = 8;
	localparam int uart_tick_bits = $clog2(uart_ticks_per_bit);

endpackage

`default_nettype wire
